/* mini_soc.f */
mini_soc_pkg.sv
apb_decode_stage.sv
boot_rom.sv
data_sram.sv
clint_timer.sv
apb_resp_stage.sv
debug_gate.sv
mini_soc_top.sv
tb_mini_soc_top.sv

/* Makefile */
TOP       ?= tb_mini_soc_top
SEED      ?= 84709
LOG       ?= sim.log
FILELIST  ?= mini_soc.f
VERILATOR ?= verilator
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run and search $(LOG) for the pass message"
	@echo "  clean  remove $(OBJ_DIR) and $(LOG)"
	@echo "  help   list the targets"
	@echo "Variables: TOP=$(TOP) SEED=$(SEED) LOG=$(LOG)"

test:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -GSeed=$(SEED) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "^TB PASSED$$" $(LOG); then \
	  echo "Simulation passed"; \
	else \
	  echo "Simulation failed, see $(LOG)"; exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* tb_mini_soc_top.sv */
`timescale 1ns/1ns

module tb_mini_soc_top #(
  parameter int unsigned Seed = 84709
);

  import mini_soc_pkg::*;

  localparam int unsigned ClkPeriod = 4;
  // Cycle budgets per test
  localparam int unsigned BudgetRom   = 300;
  localparam int unsigned BudgetSram  = 800;
  localparam int unsigned BudgetErr   = 40;
  localparam int unsigned BudgetTimer = 120;
  localparam int unsigned BudgetSoft  = 30;
  localparam int unsigned BudgetDbg   = 20;
  localparam int unsigned WatchdogCycles =
    20 * (BudgetRom + BudgetSram + BudgetErr + BudgetTimer + BudgetSoft + BudgetDbg);

  typedef enum logic [1:0] {IRQ_ANY, IRQ_LOW, IRQ_HIGH} irq_expect_e;

  logic                 clk_i;
  logic                 rst_ni;
  logic                 psel_i;
  logic                 penable_i;
  logic                 pwrite_i;
  logic [AddrWidth-1:0] paddr_i;
  logic [DataWidth-1:0] pwdata_i;
  logic [StrbWidth-1:0] pstrb_i;
  logic                 pready_o;
  logic [DataWidth-1:0] prdata_o;
  logic                 pslverr_o;
  logic                 rtc_i;
  logic                 debug_req_i;
  logic                 debug_en_i;
  logic                 timer_irq_o;
  logic                 soft_irq_o;
  logic                 debug_req_o;
  int unsigned          errors;
  int unsigned          checks;
  int unsigned          tests;
  int unsigned          cyc_q;
  irq_expect_e          irq_expect;

  mini_soc_top i_mini_soc_top (.*);

  initial begin : p_clk
    clk_i = 1'b0;
    forever #(ClkPeriod / 2) clk_i = ~clk_i;
  end

  // Cycles since reset release, saturating
  always @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      cyc_q <= 0;
    end else if (cyc_q < 1000) begin
      cyc_q <= cyc_q + 1;
    end
  end

  a_debug_gate : assert property (@(posedge clk_i) disable iff (!rst_ni)
    debug_req_o == ((cyc_q >= DbgDelayCycles) && debug_req_i && debug_en_i))
    else begin
      errors++;
      $display("** Error at %0t ns: debug_req_o wrong in cycle %0d", $time, $sampled(cyc_q));
    end

  a_timer_irq : assert property (@(posedge clk_i) disable iff (!rst_ni)
    (irq_expect != IRQ_ANY) |-> (timer_irq_o == (irq_expect == IRQ_HIGH)))
    else begin
      errors++;
      $display("** Error at %0t ns: timer_irq_o not at the expected level", $time);
    end

  task automatic step(input int unsigned n);
    repeat (n) @(posedge clk_i);
    #1;
  endtask

  task automatic check_value(input string what, input logic [DataWidth-1:0] got,
                             input logic [DataWidth-1:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("** Error at %0t ns: %s is %h, expected %h", $time, what, got, exp);
    end
  endtask

  task automatic apb_transfer(input logic wr, input logic [AddrWidth-1:0] addr,
                              input logic [DataWidth-1:0] wdata,
                              input logic [StrbWidth-1:0] strb,
                              output logic [DataWidth-1:0] rdata, output logic err);
    int unsigned waits;
    psel_i    = 1'b1;
    penable_i = 1'b0;
    pwrite_i  = wr;
    paddr_i   = addr;
    pwdata_i  = wdata;
    pstrb_i   = strb;
    step(1);
    penable_i = 1'b1;
    waits     = 0;
    @(negedge clk_i);
    while (!pready_o && waits < 8) begin
      waits++;
      @(negedge clk_i);
    end
    if (!pready_o) begin
      errors++;
      $display("The DUT never completed the transfer to address %h", addr);
    end
    rdata = prdata_o;
    err   = pslverr_o;
    step(1);
    psel_i    = 1'b0;
    penable_i = 1'b0;
    pwrite_i  = 1'b0;
  endtask

  task automatic finish_test(input string name, input int unsigned errors_before);
    tests++;
    $display("Test %s finished with %0d error(s)", name, errors - errors_before);
  endtask

  initial begin : p_main
    logic [DataWidth-1:0] rdata;
    logic [DataWidth-1:0] wdata;
    logic [DataWidth-1:0] ram_model [RamWords];
    logic [AddrWidth-1:0] bad_addr [5];
    logic [StrbWidth-1:0] strb;
    logic                 err;
    int unsigned          idx;
    int unsigned          mark;
    void'($urandom(Seed));
    bad_addr    = '{16'h3000, 16'h0F00, 16'h1100, 16'h200C, 16'h2002};
    errors      = 0;
    checks      = 0;
    tests       = 0;
    irq_expect  = IRQ_ANY;
    rst_ni      = 1'b0;
    psel_i      = 1'b0;
    penable_i   = 1'b0;
    pwrite_i    = 1'b0;
    paddr_i     = '0;
    pwdata_i    = '0;
    pstrb_i     = '0;
    rtc_i       = 1'b0;
    debug_req_i = 1'b1;
    debug_en_i  = 1'b1;
    step(3);
    rst_ni = 1'b1;
    check_value("outputs after reset",
                {pready_o, pslverr_o, timer_irq_o, soft_irq_o, debug_req_o}, '0);

    // ----------------------------------------
    mark = errors;
    for (int i = 0; i < RomWords; i++) begin
      apb_transfer(1'b0, RomBase + 16'(4 * i), '0, '0, rdata, err);
      check_value("ROM word", rdata, {16'hB007, 16'(i)});
      check_value("ROM read error flag", err, 0);
    end
    apb_transfer(1'b1, RomBase + 16'h0010, 32'h1234_5678, '1, rdata, err);
    check_value("ROM write error flag", err, 1);
    finish_test("rom", mark);

    mark = errors;
    for (int i = 0; i < RamWords; i++) begin
      ram_model[i] = $urandom;
      apb_transfer(1'b1, RamBase + 16'(4 * i), ram_model[i], '1, rdata, err);
    end
    repeat (48) begin
      idx   = $urandom_range(RamWords - 1);
      wdata = $urandom;
      strb  = StrbWidth'($urandom);
      apb_transfer(1'b1, RamBase + 16'(4 * idx), wdata, strb, rdata, err);
      check_value("SRAM write error flag", err, 0);
      for (int b = 0; b < StrbWidth; b++) begin
        if (strb[b]) ram_model[idx][8*b +: 8] = wdata[8*b +: 8];
      end
    end
    for (int i = 0; i < RamWords; i++) begin
      apb_transfer(1'b0, RamBase + 16'(4 * i), '0, '0, rdata, err);
      check_value("SRAM word", rdata, ram_model[i]);
    end
    finish_test("sram", mark);

    mark = errors;
    foreach (bad_addr[i]) begin
      apb_transfer(1'b0, bad_addr[i], '0, '0, rdata, err);
      check_value("error response flag", err, 1);
      check_value("error response data", rdata, 0);
    end
    finish_test("unmapped", mark);

    // ----------------------------------------
    mark = errors;
    apb_transfer(1'b1, ClintBase + 16'h0, 32'd0, '1, rdata, err);
    apb_transfer(1'b1, ClintBase + 16'h4, 32'd5, '1, rdata, err);
    irq_expect = IRQ_LOW;
    for (int t = 1; t <= 5; t++) begin
      // Level is in transition while the fifth tick is processed
      if (t == 5) irq_expect = IRQ_ANY;
      rtc_i = 1'b1;
      step(2);
      rtc_i = 1'b0;
      step(4);
    end
    for (int w = 0; w < 10 && !timer_irq_o; w++) step(1);
    if (!timer_irq_o) begin
      errors++;
      $display("The timer interrupt was not raised after the fifth tick");
    end
    irq_expect = IRQ_HIGH;
    step(3);
    apb_transfer(1'b0, ClintBase + 16'h0, '0, '0, rdata, err);
    check_value("MTIME after five ticks", rdata, 5);
    irq_expect = IRQ_ANY;
    finish_test("timer", mark);

    mark = errors;
    apb_transfer(1'b1, ClintBase + 16'h8, 32'd1, '1, rdata, err);
    check_value("soft_irq_o after MSIP set", soft_irq_o, 1);
    apb_transfer(1'b0, ClintBase + 16'h8, '0, '0, rdata, err);
    check_value("MSIP read", rdata, 1);
    apb_transfer(1'b1, ClintBase + 16'h8, 32'd0, '1, rdata, err);
    check_value("soft_irq_o after MSIP clear", soft_irq_o, 0);
    finish_test("soft_irq", mark);

    mark = errors;
    check_value("debug_req_o while enabled", debug_req_o, 1);
    debug_en_i = 1'b0;
    step(1);
    check_value("debug_req_o while disabled", debug_req_o, 0);
    debug_en_i = 1'b1;
    step(1);
    finish_test("debug", mark);

    $display("Tests: %0d, checks: %0d, errors: %0d", tests, checks, errors);
    if (errors == 0) begin
      $display("TB PASSED");
    end else begin
      $display("TB FAILED");
    end
    $finish;
  end

  initial begin : p_watchdog
    #(WatchdogCycles * ClkPeriod);
    $display("Timeout: the tests did not finish within %0d cycles", WatchdogCycles);
    $display("TB FAILED");
    $finish;
  end

endmodule

/* mini_soc_top.sv */
`timescale 1ns/1ns

module mini_soc_top (
  input  logic                              clk_i,
  input  logic                              rst_ni,
  input  logic                              psel_i,
  input  logic                              penable_i,
  input  logic                              pwrite_i,
  input  logic [mini_soc_pkg::AddrWidth-1:0] paddr_i,
  input  logic [mini_soc_pkg::DataWidth-1:0] pwdata_i,
  input  logic [mini_soc_pkg::StrbWidth-1:0] pstrb_i,
  output logic                              pready_o,
  output logic [mini_soc_pkg::DataWidth-1:0] prdata_o,
  output logic                              pslverr_o,
  input  logic                              rtc_i,
  input  logic                              debug_req_i,
  input  logic                              debug_en_i,
  output logic                              timer_irq_o,
  output logic                              soft_irq_o,
  output logic                              debug_req_o
);

  import mini_soc_pkg::*;

  apb_req_t req;
  tgt_rsp_t rom_rsp;
  tgt_rsp_t ram_rsp;
  tgt_rsp_t clint_rsp;
  logic     done;

  // ----------------------------------------
  // Decode, targets, response
  // ----------------------------------------
  apb_decode_stage i_decode (
    .clk_i, .rst_ni, .psel_i, .penable_i, .pwrite_i, .paddr_i, .pwdata_i, .pstrb_i,
    .done_i ( done ),
    .req_o  ( req  )
  );

  boot_rom i_boot_rom (.req_i ( req ), .rsp_o ( rom_rsp ));

  data_sram i_data_sram (.clk_i, .rst_ni, .req_i ( req ), .rsp_o ( ram_rsp ));

  clint_timer i_clint (
    .clk_i, .rst_ni, .rtc_i, .req_i ( req ), .rsp_o ( clint_rsp ), .timer_irq_o, .soft_irq_o
  );

  apb_resp_stage i_resp (
    .req_i ( req ), .rom_rsp_i ( rom_rsp ), .ram_rsp_i ( ram_rsp ),
    .clint_rsp_i ( clint_rsp ), .pready_o, .prdata_o, .pslverr_o, .done_o ( done )
  );

  debug_gate i_debug_gate (.clk_i, .rst_ni, .debug_req_i, .debug_en_i, .debug_req_o);

endmodule

/* debug_gate.sv */
`timescale 1ns/1ns

module debug_gate (
  input  logic clk_i,
  input  logic rst_ni,
  input  logic debug_req_i,
  input  logic debug_en_i,
  output logic debug_req_o
);

  import mini_soc_pkg::*;

  localparam int unsigned CntWidth = $clog2(DbgDelayCycles + 1);

  logic [CntWidth-1:0] cnt_q;

  // Hold-off window after reset
  always_ff @(posedge clk_i or negedge rst_ni) begin : p_cnt
    if (!rst_ni) begin
      cnt_q <= CntWidth'(DbgDelayCycles);
    end else if (cnt_q != '0) begin
      cnt_q <= cnt_q - 1'b1;
    end
  end

  // Pass only once the window has expired and debug is enabled
  assign debug_req_o = (cnt_q == '0) & debug_en_i & debug_req_i;

endmodule

/* apb_resp_stage.sv */
`timescale 1ns/1ns

module apb_resp_stage (
  input  mini_soc_pkg::apb_req_t              req_i,
  input  mini_soc_pkg::tgt_rsp_t              rom_rsp_i,
  input  mini_soc_pkg::tgt_rsp_t              ram_rsp_i,
  input  mini_soc_pkg::tgt_rsp_t              clint_rsp_i,
  output logic                                pready_o,
  output logic [mini_soc_pkg::DataWidth-1:0]  prdata_o,
  output logic                                pslverr_o,
  output logic                                done_o
);

  import mini_soc_pkg::*;

  tgt_rsp_t sel_rsp;

  always_comb begin
    unique case (req_i.region)
      REGION_ROM:   sel_rsp = rom_rsp_i;
      REGION_SRAM:  sel_rsp = ram_rsp_i;
      REGION_CLINT: sel_rsp = clint_rsp_i;
      // Error slave for unmapped addresses
      default: begin
        sel_rsp.rdata = '0;
        sel_rsp.ready = 1'b1;
        sel_rsp.error = 1'b1;
      end
    endcase
  end

  assign pready_o  = req_i.valid & sel_rsp.ready;
  assign pslverr_o = pready_o & sel_rsp.error;
  assign prdata_o  = sel_rsp.error ? '0 : sel_rsp.rdata;

  // Completion releases the decode stage
  assign done_o = pready_o;

endmodule

/* clint_timer.sv */
`timescale 1ns/1ns

module clint_timer (
  input  logic                   clk_i,
  input  logic                   rst_ni,
  input  logic                   rtc_i,
  input  mini_soc_pkg::apb_req_t req_i,
  output mini_soc_pkg::tgt_rsp_t rsp_o,
  output logic                   timer_irq_o,
  output logic                   soft_irq_o
);

  import mini_soc_pkg::*;

  logic [2:0]           rtc_q;
  logic                 rtc_rise;
  logic [DataWidth-1:0] mtime_q;
  logic [DataWidth-1:0] mtimecmp_q;
  logic                 msip_q;
  logic [AddrWidth-1:0] offset;
  clint_reg_e           reg_sel;
  logic                 hit;
  logic                 wr;

  assign offset = req_i.addr - ClintBase;
  assign hit    = req_i.valid && (req_i.region == REGION_CLINT);
  assign wr     = hit & req_i.write;

  always_comb begin
    case (offset[3:0])
      4'h0:    reg_sel = CLINT_MTIME;
      4'h4:    reg_sel = CLINT_MTIMECMP;
      4'h8:    reg_sel = CLINT_MSIP;
      default: reg_sel = CLINT_NONE;
    endcase
  end

  // Two-flop synchroniser plus edge detect
  assign rtc_rise = rtc_q[1] & ~rtc_q[2];

  // ----------------------------------------
  // Timer and interrupt registers
  // ----------------------------------------
  always_ff @(posedge clk_i or negedge rst_ni) begin : p_regs
    if (!rst_ni) begin
      rtc_q       <= '0;
      mtime_q     <= '0;
      mtimecmp_q  <= '1;
      msip_q      <= 1'b0;
      timer_irq_o <= 1'b0;
    end else begin
      rtc_q       <= {rtc_q[1:0], rtc_i};
      timer_irq_o <= (mtime_q >= mtimecmp_q);
      if (wr && reg_sel == CLINT_MTIME) mtime_q <= req_i.wdata;
      else if (rtc_rise)                mtime_q <= mtime_q + 1'b1;
      if (wr && reg_sel == CLINT_MTIMECMP) mtimecmp_q <= req_i.wdata;
      if (wr && reg_sel == CLINT_MSIP)     msip_q     <= req_i.wdata[0];
    end
  end

  always_comb begin
    unique case (reg_sel)
      CLINT_MTIME:    rsp_o.rdata = mtime_q;
      CLINT_MTIMECMP: rsp_o.rdata = mtimecmp_q;
      CLINT_MSIP:     rsp_o.rdata = {{(DataWidth-1){1'b0}}, msip_q};
      default:        rsp_o.rdata = '0;
    endcase
    rsp_o.ready = hit;
    rsp_o.error = hit && (reg_sel == CLINT_NONE);
  end

  assign soft_irq_o = msip_q;

  // Unused offsets never reach the registers
  a_none_no_write : assert property (@(posedge clk_i) disable iff (!rst_ni)
    (hit && reg_sel == CLINT_NONE) |=> ($stable(mtimecmp_q) && $stable(msip_q)));

endmodule

/* data_sram.sv */
`timescale 1ns/1ns

module data_sram (
  input  logic                   clk_i,
  input  logic                   rst_ni,
  input  mini_soc_pkg::apb_req_t req_i,
  output mini_soc_pkg::tgt_rsp_t rsp_o
);

  import mini_soc_pkg::*;

  localparam int unsigned IdxWidth = $clog2(RamWords);

  logic [DataWidth-1:0] mem [RamWords];
  logic [DataWidth-1:0] rdata_q;
  logic [AddrWidth-1:0] offset;
  logic [AddrWidth-3:0] word_idx;
  logic                 hit;
  logic                 phase_q;

  assign offset   = req_i.addr - RamBase;
  assign word_idx = offset[AddrWidth-1:2];
  assign hit      = req_i.valid && (req_i.region == REGION_SRAM);

  // Wait-state tracking
  always_ff @(posedge clk_i or negedge rst_ni) begin : p_phase
    if (!rst_ni) begin
      phase_q <= 1'b0;
    end else begin
      phase_q <= hit & ~phase_q;
    end
  end

  // Array access in the first access cycle
  always_ff @(posedge clk_i) begin : p_mem
    if (hit && !phase_q) begin
      if (req_i.write) begin
        for (int b = 0; b < StrbWidth; b++) begin
          if (req_i.strb[b]) mem[word_idx[IdxWidth-1:0]][8*b +: 8] <= req_i.wdata[8*b +: 8];
        end
      end
      rdata_q <= mem[word_idx[IdxWidth-1:0]];
    end
  end

  assign rsp_o.rdata = rdata_q;
  assign rsp_o.ready = hit & phase_q;
  assign rsp_o.error = 1'b0;

  a_word_in_range : assert property (@(posedge clk_i) disable iff (!rst_ni)
    hit |-> (word_idx < RamWords));

endmodule

/* boot_rom.sv */
`timescale 1ns/1ns

module boot_rom (
  input  mini_soc_pkg::apb_req_t req_i,
  output mini_soc_pkg::tgt_rsp_t rsp_o
);

  import mini_soc_pkg::*;

  localparam int unsigned IdxWidth = $clog2(RomWords);

  logic [DataWidth-1:0] rom_table [RomWords];
  logic [AddrWidth-1:0] offset;
  logic [IdxWidth-1:0]  index;
  logic                 hit;

  // Tagged word table, index in the lower half
  always_comb begin
    for (int i = 0; i < RomWords; i++) begin
      rom_table[i] = {RomTag, (DataWidth/2)'(i)};
    end
  end

  assign offset = req_i.addr - RomBase;
  assign index  = offset[IdxWidth+1:2];
  assign hit    = req_i.valid && (req_i.region == REGION_ROM);

  always_comb begin
    rsp_o.rdata = rom_table[index];
    rsp_o.ready = hit;
    // Read-only target
    rsp_o.error = hit & req_i.write;
  end

endmodule

/* apb_decode_stage.sv */
`timescale 1ns/1ns

module apb_decode_stage (
  input  logic                              clk_i,
  input  logic                              rst_ni,
  input  logic                              psel_i,
  input  logic                              penable_i,
  input  logic                              pwrite_i,
  input  logic [mini_soc_pkg::AddrWidth-1:0] paddr_i,
  input  logic [mini_soc_pkg::DataWidth-1:0] pwdata_i,
  input  logic [mini_soc_pkg::StrbWidth-1:0] pstrb_i,
  input  logic                              done_i,
  output mini_soc_pkg::apb_req_t            req_o
);

  import mini_soc_pkg::*;

  logic     setup;
  apb_req_t req_q;

  function automatic region_e decode_region(logic [AddrWidth-1:0] addr);
    if (addr >= RomBase && addr < RomBase + RomLength) return REGION_ROM;
    if (addr >= RamBase && addr < RamBase + RamLength) return REGION_SRAM;
    if (addr >= ClintBase && addr < ClintBase + ClintLength) return REGION_CLINT;
    return REGION_NONE;
  endfunction

  // Setup phase of a new transfer
  assign setup = psel_i & ~penable_i;

  always_ff @(posedge clk_i or negedge rst_ni) begin : p_req
    if (!rst_ni) begin
      req_q <= '0;
    end else if (setup) begin
      req_q.addr   <= paddr_i;
      req_q.wdata  <= pwdata_i;
      req_q.strb   <= pstrb_i;
      req_q.write  <= pwrite_i;
      req_q.region <= decode_region(paddr_i);
      req_q.valid  <= 1'b1;
    end else if (done_i) begin
      // Completion seen by the requester
      req_q.valid <= 1'b0;
    end
  end

  assign req_o = req_q;

  // Access phase only ever follows a setup cycle
  a_setup_before_access : assert property (@(posedge clk_i) disable iff (!rst_ni)
    $rose(penable_i) |-> $past(psel_i && !penable_i));

endmodule

/* mini_soc_pkg.sv */
package mini_soc_pkg;

  // ----------------------------------------
  // Widths
  // ----------------------------------------
  localparam int unsigned AddrWidth = 16;
  localparam int unsigned DataWidth = 32;
  localparam int unsigned StrbWidth = DataWidth / 8;

  // ----------------------------------------
  // Address map
  // ----------------------------------------
  localparam int unsigned RomWords = 64;
  localparam int unsigned RamWords = 64;
  localparam logic [AddrWidth-1:0] RomBase     = 16'h0000;
  localparam logic [AddrWidth-1:0] RomLength   = 16'h0100;
  localparam logic [AddrWidth-1:0] RamBase     = 16'h1000;
  localparam logic [AddrWidth-1:0] RamLength   = 16'h0100;
  localparam logic [AddrWidth-1:0] ClintBase   = 16'h2000;
  localparam logic [AddrWidth-1:0] ClintLength = 16'h0010;
  localparam logic [DataWidth/2-1:0] RomTag    = 16'hB007;

  // Debug request hold-off after reset
  localparam int unsigned DbgDelayCycles = 50;

  typedef enum logic [1:0] {
    REGION_ROM, REGION_SRAM, REGION_CLINT, REGION_NONE
  } region_e;

  typedef enum logic [1:0] {
    CLINT_MTIME, CLINT_MTIMECMP, CLINT_MSIP, CLINT_NONE
  } clint_reg_e;

  typedef struct packed {
    logic [AddrWidth-1:0] addr;
    logic [DataWidth-1:0] wdata;
    logic [StrbWidth-1:0] strb;
    logic                 write;
    region_e              region;
    logic                 valid;
  } apb_req_t;

  typedef struct packed {
    logic [DataWidth-1:0] rdata;
    logic                 ready;
    logic                 error;
  } tgt_rsp_t;

endpackage
